/* barrel_unit.f */
source/shift_pkg.sv
source/bus_pkg.sv
source/barrel32.sv
source/brlshift.sv
source/shift_pipe.sv
source/shift_regs.sv
source/barrel_unit_top.sv
dv/barrel_unit_properties.sv
dv/barrel_unit_tb.sv

/* dv/barrel_unit_properties.sv */
// Bus and pipeline timing checks
module barrel_unit_properties (
	input logic clk,
	input logic rst_n,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic launch,
	input logic in_valid,
	input logic out_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	// Ack lasts one cycle
	ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else $error("ack high on two cycles in a row");

	// Ack answers a strobe seen at the edge before
	ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> $past(cyc && stb))
		else $error("ack without cyc and stb");

	// Fixed two cycle latency, no stall
	valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> ##2 out_valid)
		else $error("out_valid missing two cycles after in_valid");
	valid_origin: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, 2))
		else $error("out_valid without in_valid two cycles before");

	launch_reset: assert property (@(posedge clk) !rst_n |=> !launch)
		else $error("launch high after reset");

endmodule

bind shift_regs barrel_unit_properties regs_props (
	.clk(clk), .rst_n(rst_n), .cyc(wb_req.cyc), .stb(wb_req.stb), .ack(ack_q),
	.launch(launch_q), .in_valid(1'b0), .out_valid(1'b0)
);

bind shift_pipe barrel_unit_properties pipe_props (
	.clk(clk), .rst_n(rst_n), .cyc(1'b0), .stb(1'b0), .ack(1'b0),
	.launch(1'b0), .in_valid(in_valid), .out_valid(out_valid)
);

/* dv/barrel_unit_tb.sv */
// Barrel unit testbench
module barrel_unit_tb import shift_pkg::*, bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Roughly 260 operations of about 12 cycles each with wide margin
	localparam int MAX_CYCLES = 20000;

	logic        clk;
	logic        rst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	int          cycles;
	int          n_sent;
	int          n_checked;
	// Handoff from stimulus to the compare process
	shift_req_t  sent_q[$];
	logic [31:0] early_q[$];
	logic [31:0] status_q[$];
	logic [31:0] result_q[$];

	barrel_unit_top #(
		.ADDR_W (8)
	) barrel_unit_top_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles == MAX_CYCLES) abort_run("Timeout, the run did not finish in time");
		end
	end

	// Expected result straight from the shift rules
	function automatic shift_res_t shift_model(input shift_op_e op, input logic [31:0] count,
		input logic [31:0] data);
		shift_res_t r;
		int         c;
		c = count;
		if (op == ROR) begin
			// Only the low five count bits matter
			r.result = (data >> count[4:0]) | (data << (6'd32 - count[4:0]));
			r.carry  = data[31];
		end else if (c >= 32 || c <= -32) begin
			r.result = (op == SHA && c > 0) ? {32{data[31]}} : 32'd0;
			r.carry  = data[0];
		end else if (c > 0) begin
			if (op == SHA) begin
				r.result = $signed(data) >>> c;
			end else begin
				r.result = data >> c;
			end
			r.carry = data[0];
		end else begin
			// Negative shifts left and zero passes the word
			r.result = data << (-c);
			r.carry  = data[31];
		end
		r.zero     = (r.result == 32'd0);
		r.negative = r.result[31];
		return r;
	endfunction

	task automatic check_result(input logic [31:0] exp, input logic [31:0] got, input string what);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t %s: read %h, expected %h", $time, what, got, exp));
		end
	endtask

	// STATUS bits 0 to 3 are done, carry, zero, negative
	task automatic check_status(input shift_res_t exp, input logic done, input logic [31:0] got,
		input string what);
		logic [31:0] want;
		want = {28'd0, exp.negative, exp.zero, exp.carry, done};
		if (got !== want) begin
			abort_run($sformatf("[FAIL] %0t %s: status %h, expected %h", $time, what, got, want));
		end
	endtask

	// Classic cycle held until ack
	// Inputs change on the falling edge
	task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, dat: dat, adr: adr};
		do begin
			@(negedge clk);
			waited++;
			if (waited > 8) abort_run("No ack from the DUT within 8 cycles");
		end while (!wb_rsp.ack);
		rdat   = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] ignored;
		bus_access(1'b1, adr, dat, sel, ignored);
	endtask

	task automatic bus_read(input logic [7:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, 32'd0, 4'hF, rdat);
	endtask

	// First STATUS read lands before done and the second 3 cycles past the CTRL ack
	task automatic run_op(input shift_op_e op, input logic [31:0] count, input logic [31:0] data);
		logic [31:0] early;
		logic [31:0] status;
		logic [31:0] result;
		bus_write(REG_COUNT, count, 4'hF);
		bus_write(REG_DATA, data, 4'hF);
		bus_write(REG_CTRL, {30'd0, op}, 4'hF);
		bus_read(REG_STATUS, early);
		bus_read(REG_STATUS, status);
		bus_read(REG_RESULT, result);
		early_q.push_back(early);
		status_q.push_back(status);
		result_q.push_back(result);
		sent_q.push_back('{op: op, count: count, data: data});
		n_sent++;
	endtask

	initial begin : compare
		shift_res_t exp;
		// Registers are zero after reset
		shift_res_t prev;
		shift_req_t sent;
		string      tag;
		prev      = '0;
		n_checked = 0;
		forever begin
			wait (n_sent > n_checked);
			sent = sent_q.pop_front();
			exp  = shift_model(sent.op, sent.count, sent.data);
			tag  = $sformatf("%s count %h data %h", sent.op.name(), sent.count, sent.data);
			// Flags still show the previous result until done
			check_status(prev, 1'b0, early_q.pop_front(), {tag, " before done"});
			check_status(exp, 1'b1, status_q.pop_front(), {tag, " after done"});
			check_result(exp.result, result_q.pop_front(), tag);
			prev = exp;
			n_checked++;
		end
	end

	initial begin : stimulus
		logic [31:0] rdat;
		logic [31:0] big [8];
		void'($urandom(32'h4317));
		rst_n  = 1'b0;
		wb_req = '0;
		n_sent = 0;
		big    = '{32'd32, -32, 32'd33, -33, 32'h7FFF_FFFF, 32'h8000_0000, 32'h0001_0000,
			32'hFFF0_0000};
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Byte lanes and unmapped offsets
		bus_write(REG_COUNT, 32'hFFFF_FFFF, 4'hF);
		bus_write(REG_COUNT, 32'h1234_5678, 4'b0101);
		bus_read(REG_COUNT, rdat);
		check_result(32'hFF34_FF78, rdat, "COUNT lane write");
		bus_write(REG_DATA, 32'd0, 4'hF);
		bus_write(REG_DATA, 32'hA5B6_C7D8, 4'b1000);
		bus_read(REG_DATA, rdat);
		check_result(32'hA500_0000, rdat, "DATA lane write");
		bus_read(8'h14, rdat);
		check_result(32'd0, rdat, "unmapped 0x14");
		bus_read(8'hFC, rdat);
		check_result(32'd0, rdat, "unmapped 0xFC");

		// Logical shifts over both SH codes
		for (int c = -31; c <= 31; c++) begin
			run_op(shift_op_e'({1'b0, c[0]}), c, $urandom());
		end
		// Out of range in both directions with both data signs under SHA
		foreach (big[i]) begin
			run_op(SH_A, big[i], $urandom());
			run_op(SHA, big[i], $urandom() | 32'h8000_0000);
			run_op(SHA, big[i], $urandom() & 32'h7FFF_FFFF);
		end
		// Sign fill on right shifts
		for (int c = -31; c <= 31; c++) begin
			run_op(SHA, c, $urandom() | 32'h8000_0000);
			run_op(SHA, c, $urandom() & 32'h7FFF_FFFF);
		end
		// Rotate with counts above 31 too
		for (int i = 0; i < 40; i++) begin
			run_op(ROR, $urandom(), $urandom());
		end
		run_op(ROR, 32'd0, $urandom());
		run_op(ROR, 32'd32, $urandom());
		// Zero and negative results
		run_op(SH_A, 32'd5, 32'd0);
		run_op(SH_A, 32'd1, 32'd1);
		run_op(SHA, -1, 32'h4000_0000);
		run_op(ROR, 32'd0, 32'h8000_0001);
		run_op(SHA, 32'd4, 32'h8000_0000);

		wait (n_checked == n_sent);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module barrel_unit_tb \
	-f barrel_unit.f -o barrel_unit_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/barrel_unit_sim > sim.log 2>&1
grep -q "Simulation FAILED" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "No pass line, see sim.log"; exit 1; }
echo "Test passed"

/* source/barrel32.sv */
// Barrel rotate core
module barrel32 import shift_pkg::*; (
	input  logic [31:0]  a,
	input  logic [4:0]   sft,
	input  barrel_mode_e mode,
	output logic [31:0]  z
);

	// Doubled word for the rotate
	logic [63:0] dbl;
	logic [31:0] rot;
	// Right amount seen by the mask, 32 minus sft
	logic [5:0]  rsft;
	// Bits kept after a left shift
	logic [31:0] lmask;
	// Bits kept after a right shift
	logic [31:0] rmask;
	// Sign word for arithmetic fill
	logic [31:0] fill;

	// Rotate left by sft
	// Upper half of the shifted pair holds the rotated word
	assign dbl = {a, a} << sft;
	assign rot = dbl[63:32];

	// Left shift drops the low sft bits that wrapped around
	assign lmask = 32'hFFFF_FFFF << sft;

	// Left rotate by sft equals right rotate by 32 minus sft
	// An sft of zero gives a right amount of 32, so the mask clears everything
	assign rsft  = 6'd32 - {1'b0, sft};
	assign rmask = 32'hFFFF_FFFF >> rsft;

	// Arithmetic fill copies the operand sign
	assign fill = {32{a[31]}};

	always_comb begin
		case (mode)
			BRL_LEFT: begin
				z = rot & lmask;
			end
			BRL_RIGHT: begin
				// Zero fill from the top
				z = rot & rmask;
			end
			BRL_ARITH: begin
				// Wrapped bits replaced by the sign
				z = (rot & rmask) | (fill & ~rmask);
			end
			default: begin
				// Plain rotate keeps every bit
				z = rot;
			end
		endcase
	end

endmodule

/* source/barrel_unit_top.sv */
// Barrel shift unit
module barrel_unit_top import shift_pkg::*, bus_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic    clk,
	input  logic    rst_n,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	// Register block to pipeline
	logic       launch;
	shift_req_t req;
	// Pipeline back to register block
	logic       out_valid;
	shift_res_t res;

	shift_regs #(
		.ADDR_W (ADDR_W)
	) shift_regs_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.launch     (launch),
		.req        (req),
		.done_valid (out_valid),
		.res        (res)
	);

	// Result is back two cycles after launch
	shift_pipe shift_pipe_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (launch),
		.req       (req),
		.out_valid (out_valid),
		.res       (res)
	);

endmodule

/* source/brlshift.sv */
// Shift count decode and carry
module brlshift import shift_pkg::*; (
	input  shift_op_e   brlmux,
	input  logic [31:0] srcdp,
	input  logic [31:0] brld,
	output logic [31:0] brlq,
	output logic        brl_carry
);

	// Two's complement of the low count bits
	logic [4:0]   neg_cnt;
	logic         is_rotate;
	logic         is_sha;
	// Sign of the whole count register
	logic         cnt_neg;
	// Low five count bits all clear
	logic         cnt_zero;
	// Any or all of count bits 30:5 set
	logic         mid_any;
	logic         mid_all;
	// Positive count of 32 or more
	logic         uflow;
	// Negative count below -31
	logic         oflow;
	// Out of range, ignored for rotate
	logic         outflow;
	logic [4:0]   shift_cnt;
	barrel_mode_e mode;

	assign is_rotate = (brlmux == ROR);
	assign is_sha    = (brlmux == SHA);

	// Core rotates left, so a right shift by n becomes a left rotate by -n
	assign neg_cnt = 5'd0 - srcdp[4:0];

	assign cnt_neg  = srcdp[31];
	assign cnt_zero = ~|srcdp[4:0];
	assign mid_any  = |srcdp[30:5];
	assign mid_all  = &srcdp[30:5];

	// Positive with any upper bit set
	assign uflow = ~cnt_neg & mid_any;

	// Negative counts from -1 to -31 have bits 30:5 all set and nonzero low bits
	// -32 has bits 30:5 set but low bits clear, still out of range
	assign oflow = cnt_neg & (~mid_all | cnt_zero);

	assign outflow = (uflow | oflow) & ~is_rotate;

	// Zero count with a right mode wipes the word in the core
	assign shift_cnt = outflow ? 5'd0 : neg_cnt;

	always_comb begin
		if (is_rotate) begin
			mode = BRL_ROTATE;
		end else if (outflow || (!cnt_neg && !cnt_zero)) begin
			// Sign fill only for a positive count under SHA
			mode = (is_sha && !cnt_neg) ? BRL_ARITH : BRL_RIGHT;
		end else begin
			// Negative in range, or a count of zero
			mode = BRL_LEFT;
		end
	end

	barrel32 brl_inst (
		.a    (brld),
		.sft  (shift_cnt),
		.mode (mode),
		.z    (brlq)
	);

	// Right modes report the last bit shifted out at the bottom
	assign brl_carry = (mode == BRL_RIGHT || mode == BRL_ARITH) ? brld[0] : brld[31];

endmodule

/* source/bus_pkg.sv */
// Wishbone bus types
package bus_pkg;

	// Master to slave, classic cycle
	// Address is kept at 8 bits, the slave uses its low ADDR_W bits
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] dat;
		logic [7:0]  adr;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic        ack;
		// Valid only while ack is high
		logic [31:0] dat;
	} wb_rsp_t;

	// Register byte offsets
	typedef enum logic [7:0] {
		// Signed shift count
		REG_COUNT  = 8'h00,
		// Operand word
		REG_DATA   = 8'h04,
		// Write launches, operation in bits 1:0
		REG_CTRL   = 8'h08,
		// Last shifted word
		REG_RESULT = 8'h0C,
		// Done, carry, zero, negative in bits 0 to 3
		REG_STATUS = 8'h10
	} reg_addr_e;

endpackage

/* source/shift_pipe.sv */
// Two stage shift pipeline
module shift_pipe import shift_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  shift_req_t req,
	output logic       out_valid,
	output shift_res_t res
);

	// Stage 1 holds the request
	logic        s1_valid;
	shift_req_t  s1_req;
	// Combinational shifter output
	logic [31:0] brl_q;
	logic        brl_c;

	// Valid bits walk one stage per cycle
	// No stall, a new request may enter every cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid  <= in_valid;
			out_valid <= s1_valid;
		end
	end

	// Stage 1 request capture
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_req <= req;
		end
	end

	// Shifter sits between the two stages
	brlshift brlshift_inst (
		.brlmux    (s1_req.op),
		.srcdp     (s1_req.count),
		.brld      (s1_req.data),
		.brlq      (brl_q),
		.brl_carry (brl_c)
	);

	// Stage 2 result and flags
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			res.result   <= brl_q;
			res.carry    <= brl_c;
			// Flags come from the shifted word, not the operand
			res.zero     <= ~|brl_q;
			res.negative <= brl_q[31];
		end
	end

endmodule

/* source/shift_pkg.sv */
// Shift unit types
package shift_pkg;

	// Host-visible operation codes, CTRL bits 1:0
	typedef enum logic [1:0] {
		// Both logical codes shift the same way
		SH_A = 2'b00,
		SH_B = 2'b01,
		// Rotate right by the low five count bits
		ROR  = 2'b10,
		// Arithmetic, sign fill on right shifts
		SHA  = 2'b11
	} shift_op_e;

	// Barrel core modes
	// Bit 0 set means a right mode, which also picks the carry source
	typedef enum logic [1:0] {
		BRL_LEFT   = 2'b00,
		BRL_RIGHT  = 2'b01,
		BRL_ROTATE = 2'b10,
		BRL_ARITH  = 2'b11
	} barrel_mode_e;

	// One request into the pipeline
	typedef struct packed {
		shift_op_e   op;
		// Signed shift count, positive shifts right
		logic [31:0] count;
		logic [31:0] data;
	} shift_req_t;

	// One result out of the pipeline
	typedef struct packed {
		logic [31:0] result;
		logic        carry;
		logic        zero;
		logic        negative;
	} shift_res_t;

endpackage

/* source/shift_regs.sv */
// Wishbone register block
module shift_regs import shift_pkg::*, bus_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  wb_req_t    wb_req,
	output wb_rsp_t    wb_rsp,
	output logic       launch,
	output shift_req_t req,
	input  logic       done_valid,
	input  shift_res_t res
);

	// Only the low ADDR_W address bits decode
	localparam logic [7:0] ADDR_MASK = 8'hFF >> (8 - ADDR_W);

	logic        ack_q;
	logic [31:0] rd_dat_q;
	logic [31:0] rd_mux;
	// Operand registers
	logic [31:0] count_q;
	logic [31:0] data_q;
	// Request held for one launch cycle
	logic        launch_q;
	shift_req_t  req_q;
	// Latched result and status
	logic        done_q;
	shift_res_t  res_q;
	// New access this cycle
	logic        access;
	logic        wr_en;
	reg_addr_e   reg_addr;

	// Byte lane merge for partial writes
	function automatic logic [31:0] merge_lanes(
		input logic [31:0] old_w,
		input logic [31:0] new_w,
		input logic [3:0]  sel
	);
		logic [31:0] w;
		w = old_w;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				w[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return w;
	endfunction

	// Ack low means the strobe is a fresh request
	assign access   = wb_req.cyc & wb_req.stb & ~ack_q;
	assign wr_en    = access & wb_req.we;
	assign reg_addr = reg_addr_e'(wb_req.adr & ADDR_MASK);

	// Read mux
	always_comb begin
		case (reg_addr)
			REG_COUNT:  rd_mux = count_q;
			REG_DATA:   rd_mux = data_q;
			// Last launched operation
			REG_CTRL:   rd_mux = {30'd0, req_q.op};
			REG_RESULT: rd_mux = res_q.result;
			REG_STATUS: rd_mux = {28'd0, res_q.negative, res_q.zero, res_q.carry, done_q};
			// Unmapped offsets read zero
			default:    rd_mux = 32'd0;
		endcase
	end

	// Single cycle ack
	// A held strobe sees ack drop, then gets served again
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// Read data registered with the ack
	always_ff @(posedge clk) begin
		if (access) begin
			rd_dat_q <= rd_mux;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count_q  <= 32'd0;
			data_q   <= 32'd0;
			launch_q <= 1'b0;
			req_q    <= '0;
			done_q   <= 1'b0;
			res_q    <= '0;
		end else begin
			launch_q <= 1'b0;
			if (wr_en && reg_addr == REG_COUNT) begin
				count_q <= merge_lanes(count_q, wb_req.dat, wb_req.sel);
			end
			if (wr_en && reg_addr == REG_DATA) begin
				data_q <= merge_lanes(data_q, wb_req.dat, wb_req.sel);
			end
			// Pipeline result lands one cycle after out_valid
			if (done_valid) begin
				done_q <= 1'b1;
				res_q  <= res;
			end
			// Launch wins over a result arriving the same cycle
			if (wr_en && reg_addr == REG_CTRL) begin
				launch_q <= 1'b1;
				req_q    <= '{op: shift_op_e'(wb_req.dat[1:0]), count: count_q, data: data_q};
				done_q   <= 1'b0;
			end
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_dat_q;
	assign launch     = launch_q;
	assign req        = req_q;

endmodule
